// File: Makefile
VERILATOR  ?= verilator
TOP        := cpu_tb
FILELIST   := tb.f
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb
	import isa_pkg::*;
	import ctrl_pkg::*;
();

	logic      clk;
	logic      rst;
	logic      req;
	host_cmd_t cmd;
	logic      ack;
	host_rsp_t rsp;

	// reference model state
	logic [`CPU_DATA_W-1:0] mregs [`CPU_REG_N];
	logic [`CPU_DATA_W-1:0] mmem [`CPU_MEM_DEPTH];
	logic [`CPU_DATA_W-1:0] model_pc;

	int     errors;
	int     checks;
	logic   aborted;
	integer seed;

	cpu_top dut_i (
		.clk (clk),
		.rst (rst),
		.req (req),
		.cmd (cmd),
		.ack (ack),
		.rsp (rsp)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// later checks are skipped once a handshake has timed out
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (!aborted) begin
			checks++;
			if (got !== exp) begin
				$display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
				errors++;
			end
		end
	endtask

	function automatic logic [31:0] pack_r(opcode_t op, logic [3:0] ra, logic [3:0] rb,
			logic [3:0] rc);
		return {op, ra, rb, rc, 15'h0};
	endfunction

	function automatic logic [31:0] pack_i(opcode_t op, logic [3:0] ra, logic [3:0] rb,
			logic [18:0] imm);
		return {op, ra, rb, imm};
	endfunction

	// fetch takes 3 steps before the execute steps
	function automatic int steps_for(logic [4:0] op);
		case (opcode_t'(op))
			op_ld, op_st: return 8;
			op_jr:        return 4;
			default:      return 6;
		endcase
	endfunction

	function automatic void model_exec(logic [31:0] word);
		opcode_t     op;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [31:0] imm;
		logic [31:0] base;
		logic [31:0] addr;
		op = opcode_t'(word[31:27]);
		ra = word[26:23];
		rb = word[22:19];
		rc = word[18:15];
		imm = {{13{word[18]}}, word[18:0]};
		// base addressing treats r0 as zero
		base = (rb == 4'd0) ? 32'd0 : mregs[rb];
		addr = base + imm;
		model_pc = model_pc + 32'd1;
		case (op)
			op_ldi, op_addi: mregs[ra] = addr;
			op_add:          mregs[ra] = mregs[rb] + mregs[rc];
			op_sub:          mregs[ra] = mregs[rb] - mregs[rc];
			op_and:          mregs[ra] = mregs[rb] & mregs[rc];
			op_or:           mregs[ra] = mregs[rb] | mregs[rc];
			op_ld:           mregs[ra] = mmem[addr[`CPU_MEM_AW-1:0]];
			op_st:           mmem[addr[`CPU_MEM_AW-1:0]] = mregs[ra];
			op_jr:           model_pc = mregs[ra];
			default: ;
		endcase
	endfunction

	task automatic reset_dut();
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
	endtask

	task automatic wait_ack(input logic level, input int limit, output int cycles,
			output logic ok);
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < limit) begin
			@(posedge clk);
			#1;
			cycles++;
			ok = (ack === level);
		end
	endtask

	task automatic raise_req(input host_op_t op, input logic [15:0] addr,
			input logic [31:0] wdata, output int cycles);
		logic ok;
		cycles = 0;
		if (!aborted) begin
			@(posedge clk);
			#1;
			cmd.op = op;
			cmd.addr = addr;
			cmd.wdata = wdata;
			req = 1'b1;
			wait_ack(1'b1, 20, cycles, ok);
			if (!ok) begin
				$display("timeout: ack never rose for %s at addr 0x%04h", op.name(), addr);
				errors++;
				aborted = 1'b1;
				req = 1'b0;
			end
		end
	endtask

	task automatic drop_req();
		int   cycles;
		logic ok;
		if (!aborted) begin
			req = 1'b0;
			wait_ack(1'b0, 5, cycles, ok);
			if (!ok) begin
				$display("timeout: ack stayed high after req was dropped");
				errors++;
				aborted = 1'b1;
			end
		end
	endtask

	task automatic host_cmd_do(input host_op_t op, input logic [15:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output int cycles);
		raise_req(op, addr, wdata, cycles);
		rdata = rsp.rdata;
		drop_req();
		// plain accesses ack on the second cycle
		if (op != host_step)
			check_val("host_ack_cycles", cycles, 32'd2);
	endtask

	task automatic load_word(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		int          cycles;
		host_cmd_do(host_mem_write, addr, data, rd, cycles);
		mmem[addr[`CPU_MEM_AW-1:0]] = data;
	endtask

	task automatic read_mem(input logic [15:0] addr, output logic [31:0] data);
		int cycles;
		host_cmd_do(host_mem_read, addr, 32'h0, data, cycles);
	endtask

	task automatic read_reg(input logic [3:0] idx, output logic [31:0] data);
		int cycles;
		host_cmd_do(host_reg_read, {12'h0, idx}, 32'h0, data, cycles);
	endtask

	task automatic read_pc(output logic [31:0] data);
		int cycles;
		host_cmd_do(host_pc_read, 16'h0, 32'h0, data, cycles);
	endtask

	task automatic step_cpu(output int cycles);
		logic [31:0] rd;
		host_cmd_do(host_step, 16'h0, 32'h0, rd, cycles);
	endtask

	// instruction already sits at the model pc
	task automatic step_and_model(input logic [31:0] word);
		int cycles;
		step_cpu(cycles);
		check_val("step_ack_cycles", cycles, 32'(steps_for(word[31:27]) + 2));
		model_exec(word);
	endtask

	task automatic exec_instr(input logic [31:0] word);
		load_word(model_pc[15:0], word);
		step_and_model(word);
	endtask

	task automatic compare_all_regs();
		logic [31:0] v;
		for (int r = 1; r < `CPU_REG_N; r++) begin
			read_reg(r[3:0], v);
			check_val($sformatf("r%0d", r), v, mregs[r]);
		end
	endtask

	task automatic reset_state_zero();
		logic [31:0] v;
		check_val("ack", 32'(ack), 32'd0);
		read_pc(v);
		check_val("pc", v, 32'd0);
		compare_all_regs();
	endtask

	task automatic ldi_sign_extend();
		logic [31:0] v;
		exec_instr(pack_i(op_ldi, 4'd6, 4'd0, 19'h0000f));
		// -5 and then r6 - 16
		exec_instr(pack_i(op_ldi, 4'd7, 4'd0, 19'h7fffb));
		exec_instr(pack_i(op_ldi, 4'd8, 4'd6, 19'h7fff0));
		read_reg(4'd6, v);
		check_val("r6", v, 32'h0000_000f);
		read_reg(4'd7, v);
		check_val("r7", v, 32'hffff_fffb);
		read_reg(4'd8, v);
		check_val("r8", v, 32'hffff_ffff);
	endtask

	task automatic alu_ops_random();
		int r;
		for (int round = 0; round < 4; round++) begin
			r = $random(seed);
			exec_instr(pack_i(op_ldi, 4'd1, 4'd0, r[18:0]));
			r = $random(seed);
			exec_instr(pack_i(op_ldi, 4'd2, 4'd0, r[18:0]));
			r = $random(seed);
			exec_instr(pack_i(op_addi, 4'd3, 4'd1, r[18:0]));
			exec_instr(pack_r(op_add, 4'd4, 4'd1, 4'd2));
			exec_instr(pack_r(op_sub, 4'd5, 4'd1, 4'd2));
			exec_instr(pack_r(op_and, 4'd9, 4'd1, 4'd2));
			exec_instr(pack_r(op_or, 4'd10, 4'd2, 4'd3));
			compare_all_regs();
		end
	endtask

	task automatic load_store_offsets();
		logic [31:0] v;
		load_word(16'h0140, 32'h1234_5678);
		load_word(16'h0141, 32'h8000_00a5);
		exec_instr(pack_i(op_ldi, 4'd11, 4'd0, 19'h00100));
		exec_instr(pack_i(op_ld, 4'd12, 4'd11, 19'h00040));
		exec_instr(pack_i(op_ld, 4'd13, 4'd0, 19'h00141));
		read_reg(4'd12, v);
		check_val("r12", v, 32'h1234_5678);
		read_reg(4'd13, v);
		check_val("r13", v, 32'h8000_00a5);
		// one positive and one negative offset
		exec_instr(pack_i(op_st, 4'd12, 4'd11, 19'h00020));
		exec_instr(pack_i(op_st, 4'd3, 4'd11, 19'h7fff0));
		read_mem(16'h0120, v);
		check_val("mem[0x120]", v, mmem[9'h120]);
		read_mem(16'h00f0, v);
		check_val("mem[0x0f0]", v, mmem[9'h0f0]);
		compare_all_regs();
	endtask

	task automatic jump_register();
		logic [31:0] v;
		logic [31:0] target_word;
		target_word = pack_i(op_ldi, 4'd15, 4'd0, 19'h002a5);
		exec_instr(pack_i(op_ldi, 4'd14, 4'd0, 19'h00080));
		load_word(16'h0080, target_word);
		exec_instr(pack_r(op_jr, 4'd14, 4'd0, 4'd0));
		read_pc(v);
		check_val("pc", v, 32'h0000_0080);
		check_val("pc_model", v, model_pc);
		step_and_model(target_word);
		read_reg(4'd15, v);
		check_val("r15", v, 32'h0000_02a5);
		read_pc(v);
		check_val("pc", v, model_pc);
	endtask

	task automatic req_backpressure();
		logic [31:0] held;
		int          cycles;
		raise_req(host_mem_read, 16'h0140, 32'h0, cycles);
		held = rsp.rdata;
		check_val("rsp.rdata", held, mmem[9'h140]);
		// ack and rsp must not move while req stays high
		repeat (10) begin
			@(posedge clk);
			#1;
			check_val("ack", 32'(ack), 32'd1);
			check_val("rsp.rdata", rsp.rdata, held);
		end
		drop_req();
	endtask

	initial begin
		seed = 66;
		errors = 0;
		checks = 0;
		aborted = 1'b0;
		req = 1'b0;
		cmd = '0;
		rst = 1'b1;
		model_pc = '0;
		for (int i = 0; i < `CPU_REG_N; i++)
			mregs[i] = '0;
		for (int i = 0; i < `CPU_MEM_DEPTH; i++)
			mmem[i] = '0;

		reset_dut();
		reset_state_zero();
		ldi_sign_extend();
		alu_ops_random();
		load_store_offsets();
		jump_register();
		req_backpressure();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu
	import isa_pkg::*;
(
	input  opcode_t                alu_op,
	input  logic [`CPU_DATA_W-1:0] y_in,
	input  logic [`CPU_DATA_W-1:0] bus_in,
	output logic [`CPU_DATA_W-1:0] result
);

	// Y is always the A operand, the bus is B
	always_comb begin
		case (alu_op)
			// immediate and memory forms form an address or sum
			op_add, op_addi, op_ldi, op_ld, op_st:
				result = y_in + bus_in;
			op_sub:
				result = y_in - bus_in;
			op_and:
				result = y_in & bus_in;
			op_or:
				result = y_in | bus_in;
			// anything else just passes B through
			default:
				result = bus_in;
		endcase
	end

endmodule

// File: hw/control_unit.sv
`timescale 1ns/1ps

module control_unit
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       step_go,
	input  instr_u     ir,
	output ctrl_word_t ctrl,
	output logic       step_done
);

	logic       busy;
	logic [2:0] step;
	logic [2:0] last_step;
	logic       is_alu_r;
	logic       is_alu_i;
	logic       is_mem;
	opcode_t    op;

	assign op       = ir.r.opcode;
	assign is_alu_r = op inside {op_add, op_sub, op_and, op_or};
	assign is_alu_i = op inside {op_ldi, op_addi};
	assign is_mem   = op inside {op_ld, op_st};

	// never below 3, IR is still the old word during fetch
	always_comb begin
		if (is_mem)
			last_step = 3'd7;
		else if (is_alu_r || is_alu_i)
			last_step = 3'd5;
		else
			last_step = 3'd3;
	end

	assign step_done = busy && (step == last_step);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			step <= '0;
		end else if (step_go) begin
			busy <= 1'b1;
			step <= '0;
		end else if (busy) begin
			if (step == last_step) begin
				busy <= 1'b0;
				step <= '0;
			end else begin
				step <= step + 1'b1;
			end
		end
	end

	always_comb begin
		ctrl = '0;
		if (busy) begin
			case (step)
				// fetch
				3'd0: begin
					ctrl.bus_src      = bus_pc;
					ctrl.mar_enable   = 1'b1;
					ctrl.pc_increment = 1'b1;
					ctrl.z_enable     = 1'b1;
				end
				3'd1: begin
					ctrl.bus_src    = bus_zlo;
					ctrl.read       = 1'b1;
					ctrl.mdr_enable = 1'b1;
					ctrl.pc_enable  = 1'b1;
				end
				3'd2: begin
					ctrl.bus_src   = bus_mdr;
					ctrl.ir_enable = 1'b1;
				end
				// Rb into Y, or Ra into pc for jr
				3'd3: begin
					ctrl.bus_src = bus_reg;
					if (op == op_jr) begin
						ctrl.gra       = 1'b1;
						ctrl.pc_enable = 1'b1;
					end else if (is_alu_r || is_alu_i || is_mem) begin
						ctrl.grb      = 1'b1;
						ctrl.ba_out   = !is_alu_r;
						ctrl.y_enable = 1'b1;
					end
				end
				3'd4: begin
					ctrl.alu_op   = op;
					ctrl.z_enable = 1'b1;
					if (is_alu_r) begin
						ctrl.bus_src = bus_reg;
						ctrl.grc     = 1'b1;
					end else begin
						ctrl.bus_src = bus_imm;
					end
				end
				3'd5: begin
					ctrl.bus_src = bus_zlo;
					if (is_mem) begin
						ctrl.mar_enable = 1'b1;
					end else begin
						ctrl.gra  = 1'b1;
						ctrl.r_in = 1'b1;
					end
				end
				3'd6: begin
					ctrl.mdr_enable = 1'b1;
					if (op == op_ld) begin
						ctrl.read = 1'b1;
					end else begin
						ctrl.bus_src = bus_reg;
						ctrl.gra     = 1'b1;
					end
				end
				default: begin
					if (op == op_ld) begin
						ctrl.bus_src = bus_mdr;
						ctrl.gra     = 1'b1;
						ctrl.r_in    = 1'b1;
					end else begin
						ctrl.ram_write = 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      req,
	input  host_cmd_t cmd,
	output logic      ack,
	output host_rsp_t rsp
);

	ctrl_word_t             ctrl;
	instr_u                 ir;
	logic                   step_go;
	logic                   step_done;
	logic [`CPU_MEM_AW-1:0] mem_addr;
	logic [`CPU_DATA_W-1:0] mem_wdata;
	logic                   mem_read;
	logic                   mem_write;
	logic [`CPU_DATA_W-1:0] mem_rdata;
	logic [`CPU_DATA_W-1:0] ram_rdata;
	logic [`CPU_MEM_AW-1:0] host_mem_addr;
	logic [`CPU_DATA_W-1:0] host_mem_wdata;
	logic                   host_mem_we;
	logic [`CPU_DATA_W-1:0] host_mem_rdata;
	logic [`CPU_REG_SW-1:0] dbg_sel;
	logic [`CPU_DATA_W-1:0] dbg_data;
	logic [`CPU_DATA_W-1:0] pc_value;

	// read data only returns to the datapath during a read step
	assign mem_rdata = mem_read ? ram_rdata : '0;

	host_port u_host_port (
		.clk            (clk),
		.rst            (rst),
		.req            (req),
		.cmd            (cmd),
		.ack            (ack),
		.rsp            (rsp),
		.step_go        (step_go),
		.step_done      (step_done),
		.host_mem_addr  (host_mem_addr),
		.host_mem_wdata (host_mem_wdata),
		.host_mem_we    (host_mem_we),
		.host_mem_rdata (host_mem_rdata),
		.dbg_sel        (dbg_sel),
		.dbg_data       (dbg_data),
		.pc_value       (pc_value)
	);

	control_unit u_control_unit (
		.clk       (clk),
		.rst       (rst),
		.step_go   (step_go),
		.ir        (ir),
		.ctrl      (ctrl),
		.step_done (step_done)
	);

	datapath u_datapath (
		.clk       (clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.ir        (ir),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_rdata (mem_rdata),
		.dbg_sel   (dbg_sel),
		.dbg_data  (dbg_data),
		.pc_value  (pc_value)
	);

	ram u_ram (
		.clk        (clk),
		.cpu_addr   (mem_addr),
		.cpu_wdata  (mem_wdata),
		.cpu_we     (mem_write),
		.cpu_rdata  (ram_rdata),
		.host_addr  (host_mem_addr),
		.host_wdata (host_mem_wdata),
		.host_we    (host_mem_we),
		.host_rdata (host_mem_rdata)
	);

endmodule

// File: hw/ctrl_pkg.sv
`include "cpu_config.svh"

package ctrl_pkg;
	import isa_pkg::*;

	// who drives the shared bus this cycle
	typedef enum logic [2:0] {
		bus_none,
		bus_pc,
		bus_zlo,
		bus_mdr,
		bus_reg,
		bus_imm
	} bus_src_t;

	typedef struct packed {
		bus_src_t bus_src;
		logic     pc_enable;
		logic     pc_increment;
		logic     mar_enable;
		logic     mdr_enable;
		logic     read;
		logic     ram_write;
		logic     ir_enable;
		logic     y_enable;
		logic     z_enable;
		logic     r_in;
		logic     gra;
		logic     grb;
		logic     grc;
		logic     ba_out;
		opcode_t  alu_op;
	} ctrl_word_t;

	typedef enum logic [2:0] {
		host_step,
		host_mem_write,
		host_mem_read,
		host_reg_read,
		host_pc_read
	} host_op_t;

	typedef struct packed {
		host_op_t                op;
		logic [15:0]             addr;
		logic [`CPU_DATA_W-1:0]  wdata;
	} host_cmd_t;

	typedef struct packed {
		logic [`CPU_DATA_W-1:0] rdata;
	} host_rsp_t;

endpackage

// File: hw/datapath.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module datapath
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  ctrl_word_t             ctrl,
	output instr_u                 ir,
	output logic [`CPU_MEM_AW-1:0] mem_addr,
	output logic [`CPU_DATA_W-1:0] mem_wdata,
	output logic                   mem_read,
	output logic                   mem_write,
	input  logic [`CPU_DATA_W-1:0] mem_rdata,
	input  logic [`CPU_REG_SW-1:0] dbg_sel,
	output logic [`CPU_DATA_W-1:0] dbg_data,
	output logic [`CPU_DATA_W-1:0] pc_value
);

	logic [`CPU_DATA_W-1:0] bus;
	logic [`CPU_DATA_W-1:0] pc_q;
	logic [`CPU_DATA_W-1:0] y_q;
	logic [`CPU_DATA_W-1:0] z_q;
	logic [`CPU_DATA_W-1:0] mar_q;
	logic [`CPU_DATA_W-1:0] mdr_q;
	logic [`CPU_DATA_W-1:0] reg_out;
	logic [`CPU_DATA_W-1:0] alu_result;
	logic [`CPU_DATA_W-1:0] imm_ext;
	instr_u                 ir_q;

	// sign extend the 19-bit immediate
	assign imm_ext = {{(`CPU_DATA_W - 19){ir_q.i.imm19[18]}}, ir_q.i.imm19};

	// one driver on the bus per cycle
	always_comb begin
		case (ctrl.bus_src)
			bus_pc:  bus = pc_q;
			bus_zlo: bus = z_q;
			bus_mdr: bus = mdr_q;
			bus_reg: bus = reg_out;
			bus_imm: bus = imm_ext;
			default: bus = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= '0;
			ir_q <= '0;
		end else begin
			if (ctrl.pc_enable)
				pc_q <= bus;
			if (ctrl.ir_enable)
				ir_q <= bus;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.y_enable)
			y_q <= bus;
		// fetch uses Z to hold the next pc
		if (ctrl.z_enable)
			z_q <= ctrl.pc_increment ? pc_q + 1'b1 : alu_result;
		if (ctrl.mar_enable)
			mar_q <= bus;
		if (ctrl.mdr_enable)
			mdr_q <= ctrl.read ? mem_rdata : bus;
	end

	reg_file u_reg_file (
		.clk      (clk),
		.rst      (rst),
		.ir       (ir_q),
		.gra      (ctrl.gra),
		.grb      (ctrl.grb),
		.grc      (ctrl.grc),
		.ba_out   (ctrl.ba_out),
		.r_in     (ctrl.r_in),
		.bus_in   (bus),
		.reg_out  (reg_out),
		.dbg_sel  (dbg_sel),
		.dbg_data (dbg_data)
	);

	alu u_alu (
		.alu_op (ctrl.alu_op),
		.y_in   (y_q),
		.bus_in (bus),
		.result (alu_result)
	);

	assign ir        = ir_q;
	assign mem_addr  = mar_q[`CPU_MEM_AW-1:0];
	assign mem_wdata = mdr_q;
	assign mem_read  = ctrl.read;
	assign mem_write = ctrl.ram_write;
	assign pc_value  = pc_q;

endmodule

// File: hw/host_port.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module host_port
	import ctrl_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req,
	input  host_cmd_t              cmd,
	output logic                   ack,
	output host_rsp_t              rsp,
	output logic                   step_go,
	input  logic                   step_done,
	output logic [`CPU_MEM_AW-1:0] host_mem_addr,
	output logic [`CPU_DATA_W-1:0] host_mem_wdata,
	output logic                   host_mem_we,
	input  logic [`CPU_DATA_W-1:0] host_mem_rdata,
	output logic [`CPU_REG_SW-1:0] dbg_sel,
	input  logic [`CPU_DATA_W-1:0] dbg_data,
	input  logic [`CPU_DATA_W-1:0] pc_value
);

	typedef enum logic [1:0] {
		st_idle,
		st_access,
		st_step,
		st_ack
	} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= st_idle;
			ack     <= 1'b0;
			step_go <= 1'b0;
		end else begin
			step_go <= 1'b0;
			case (state)
				st_idle: begin
					if (req && cmd.op == host_step) begin
						step_go <= 1'b1;
						state   <= st_step;
					end else if (req) begin
						state <= st_access;
					end
				end
				st_access: begin
					ack   <= 1'b1;
					state <= st_ack;
				end
				st_step: begin
					if (step_done) begin
						ack   <= 1'b1;
						state <= st_ack;
					end
				end
				// hold ack until the host lets go of req
				default: begin
					if (!req) begin
						ack   <= 1'b0;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// response captured on the edge that raises ack
	always_ff @(posedge clk) begin
		if (state == st_access) begin
			case (cmd.op)
				host_mem_read: rsp.rdata <= host_mem_rdata;
				host_reg_read: rsp.rdata <= dbg_data;
				host_pc_read:  rsp.rdata <= pc_value;
				default:       rsp.rdata <= cmd.wdata;
			endcase
		end else if (state == st_step && step_done) begin
			rsp.rdata <= '0;
		end
	end

	assign host_mem_addr  = cmd.addr[`CPU_MEM_AW-1:0];
	assign host_mem_wdata = cmd.wdata;
	assign host_mem_we    = (state == st_access) && (cmd.op == host_mem_write);
	assign dbg_sel        = cmd.addr[`CPU_REG_SW-1:0];

endmodule

// File: hw/isa_pkg.sv
package isa_pkg;

	// opcode field, encodings kept from the full instruction set
	typedef enum logic [4:0] {
		op_ld   = 5'd0,
		op_ldi  = 5'd1,
		op_st   = 5'd2,
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_addi = 5'd12,
		op_jr   = 5'd20
	} opcode_t;

	// three-register format
	typedef struct packed {
		opcode_t     opcode;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [14:0] unused;
	} instr_r_t;

	// immediate format, imm19 is sign extended
	typedef struct packed {
		opcode_t     opcode;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [18:0] imm19;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

// File: hw/ram.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module ram (
	input  logic                   clk,
	input  logic [`CPU_MEM_AW-1:0] cpu_addr,
	input  logic [`CPU_DATA_W-1:0] cpu_wdata,
	input  logic                   cpu_we,
	output logic [`CPU_DATA_W-1:0] cpu_rdata,
	input  logic [`CPU_MEM_AW-1:0] host_addr,
	input  logic [`CPU_DATA_W-1:0] host_wdata,
	input  logic                   host_we,
	output logic [`CPU_DATA_W-1:0] host_rdata
);

	logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];

	// ports never write together, host only touches memory while the cpu is idle
	always_ff @(posedge clk) begin
		if (cpu_we)
			mem[cpu_addr] <= cpu_wdata;
		if (host_we)
			mem[host_addr] <= host_wdata;
	end

	assign cpu_rdata  = mem[cpu_addr];
	assign host_rdata = mem[host_addr];

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file
	import isa_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  instr_u                 ir,
	input  logic                   gra,
	input  logic                   grb,
	input  logic                   grc,
	input  logic                   ba_out,
	input  logic                   r_in,
	input  logic [`CPU_DATA_W-1:0] bus_in,
	output logic [`CPU_DATA_W-1:0] reg_out,
	input  logic [`CPU_REG_SW-1:0] dbg_sel,
	output logic [`CPU_DATA_W-1:0] dbg_data
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];
	logic [`CPU_REG_SW-1:0] sel;

	// ra/rb sit at the same bits in both formats
	always_comb begin
		if (gra)
			sel = ir.r.ra;
		else if (grb)
			sel = ir.r.rb;
		else if (grc)
			sel = ir.r.rc;
		else
			sel = '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_N; i++)
				regs[i] <= '0;
		end else if (r_in) begin
			regs[sel] <= bus_in;
		end
	end

	// base addressing, r0 reads as zero
	assign reg_out = (ba_out && sel == '0) ? '0 : regs[sel];

	assign dbg_data = regs[dbg_sel];

endmodule

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// machine word and register file size
`define CPU_DATA_W 32
`define CPU_REG_N 16

// word-addressed memory
`define CPU_MEM_DEPTH 512

// derived select widths
`define CPU_MEM_AW ($clog2(`CPU_MEM_DEPTH))
`define CPU_REG_SW ($clog2(`CPU_REG_N))

`endif

// File: tb.f
+incdir+include
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/datapath.sv
hw/control_unit.sv
hw/ram.sv
hw/host_port.sv
hw/cpu_top.sv
bench/cpu_tb.sv
